//--- rtl/lsu_pkg.sv
package lsu_pkg;

    localparam int XLEN       = 32;
    localparam int STRB_W     = XLEN / 8;
    localparam int ORDER_W    = 64;
    localparam int NUM_STAGES = 3;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic [ORDER_W-1:0] order_t;
    typedef logic [2:0]         funct3_t;

    // first commit wraps to zero
    localparam order_t ORDER_RESET = '1;

    typedef enum funct3_t {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        lbu = 3'd4,
        lhu = 3'd5
    } load_funct3_e;

    typedef enum funct3_t {
        sb = 3'd0,
        sh = 3'd1,
        sw = 3'd2
    } store_funct3_e;

endpackage : lsu_pkg

//--- rtl/mem_access_decode.sv
module mem_access_decode
    import lsu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    in_valid_i,
    output logic    in_ready_o,
    input  logic    is_store_i,
    input  funct3_t funct3_i,
    input  word_t   addr_i,
    input  word_t   wdata_i,

    output logic    out_valid_o,
    input  logic    out_ready_i,
    output word_t   out_addr_o,
    output strb_t   out_mask_o,
    output word_t   out_wdata_o,
    output logic    out_is_store_o,
    output logic    out_trap_o
);

    logic [1:0] offset;
    logic       is_byte, is_half, is_word, bad_f3;
    word_t      d_addr, d_wdata;
    strb_t      d_mask;
    logic       d_trap;

    assign offset     = addr_i[1:0];
    assign in_ready_o = !out_valid_o || out_ready_i; // empty or draining

    always_comb begin : size_sel
        is_byte = 1'b0;
        is_half = 1'b0;
        is_word = 1'b0;
        bad_f3  = 1'b0;
        if (is_store_i) begin
            case (funct3_i)
                sb:      is_byte = 1'b1;
                sh:      is_half = 1'b1;
                sw:      is_word = 1'b1;
                default: bad_f3  = 1'b1;
            endcase
        end else begin
            case (funct3_i)
                lb, lbu: is_byte = 1'b1;
                lh, lhu: is_half = 1'b1;
                lw:      is_word = 1'b1;
                default: bad_f3  = 1'b1;
            endcase
        end
    end

    always_comb begin : lane_calc
        d_trap  = bad_f3 || (is_word && offset != 2'd0) || (is_half && offset[0]);
        d_addr  = {addr_i[XLEN-1:2], 2'b00};
        d_mask  = '0;
        d_wdata = '0;
        if (d_trap) begin
            d_addr = addr_i; // keep faulting address
        end else begin
            if (is_word)
                d_mask = '1;
            else if (is_half)
                d_mask = strb_t'(2'b11) << offset;
            else
                d_mask = strb_t'(1'b1) << offset;
            if (is_store_i)
                d_wdata = wdata_i << {offset, 3'b000}; // move to byte lane
        end
    end

    always_ff @(posedge clk, posedge rst) begin : valid_reg
        if (rst)
            out_valid_o <= 1'b0;
        else if (in_ready_o)
            out_valid_o <= in_valid_i;
    end

    always_ff @(posedge clk) begin : payload_reg
        if (in_valid_i && in_ready_o) begin
            out_addr_o     <= d_addr;
            out_mask_o     <= d_mask;
            out_wdata_o    <= d_wdata;
            out_is_store_o <= is_store_i;
            out_trap_o     <= d_trap;
        end
    end

    a_mask_nonzero: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_trap_o |-> out_mask_o != '0);

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_addr_o)
            && $stable(out_mask_o) && $stable(out_wdata_o)
            && $stable(out_is_store_o) && $stable(out_trap_o));

endmodule : mem_access_decode

//--- rtl/pipe_stage.sv
module pipe_stage
    import lsu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  in_valid_i,
    output logic  in_ready_o,
    input  word_t in_addr_i,
    input  strb_t in_mask_i,
    input  word_t in_wdata_i,
    input  logic  in_is_store_i,
    input  logic  in_trap_i,

    output logic  out_valid_o,
    input  logic  out_ready_i,
    output word_t out_addr_o,
    output strb_t out_mask_o,
    output word_t out_wdata_o,
    output logic  out_is_store_o,
    output logic  out_trap_o
);

    logic load;

    assign in_ready_o = !out_valid_o || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk, posedge rst) begin : valid_reg
        if (rst)
            out_valid_o <= 1'b0;
        else if (in_ready_o)
            out_valid_o <= in_valid_i; // refill or go empty
    end

    always_ff @(posedge clk) begin : payload_reg
        if (load) begin
            out_addr_o     <= in_addr_i;
            out_mask_o     <= in_mask_i;
            out_wdata_o    <= in_wdata_i;
            out_is_store_o <= in_is_store_i;
            out_trap_o     <= in_trap_i;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_addr_o)
            && $stable(out_mask_o) && $stable(out_wdata_o)
            && $stable(out_is_store_o) && $stable(out_trap_o));

endmodule : pipe_stage

//--- rtl/commit_tagger.sv
module commit_tagger
    import lsu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  logic   in_valid_i,
    output logic   in_ready_o,
    output order_t in_order_o,

    input  logic   out_ready_i
);

    order_t order_q;
    logic   commit;

    assign in_ready_o = out_ready_i; // no storage here
    assign commit     = in_valid_i && out_ready_i;
    assign in_order_o = order_q + order_t'(1);

    always_ff @(posedge clk, posedge rst) begin : order_reg
        if (rst)
            order_q <= ORDER_RESET;
        else if (commit)
            order_q <= in_order_o;
    end

    // order only moves with a leaving request
    a_order_hold: assert property (@(posedge clk) disable iff (rst)
        !commit |=> $stable(order_q));

endmodule : commit_tagger

//--- rtl/lsu_pipe_top.sv
module lsu_pipe_top
    import lsu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    in_valid_i,
    output logic    in_ready_o,
    input  logic    is_store_i,
    input  funct3_t funct3_i,
    input  word_t   addr_i,
    input  word_t   wdata_i,

    output logic    out_valid_o,
    input  logic    out_ready_i,
    output word_t   out_addr_o,
    output strb_t   out_mask_o,
    output word_t   out_wdata_o,
    output logic    out_is_store_o,
    output logic    out_trap_o,
    output order_t  out_order_o
);

    logic  link_valid [0:NUM_STAGES];
    logic  link_ready [0:NUM_STAGES];
    word_t link_addr  [0:NUM_STAGES];
    strb_t link_mask  [0:NUM_STAGES];
    word_t link_wdata [0:NUM_STAGES];
    logic  link_store [0:NUM_STAGES];
    logic  link_trap  [0:NUM_STAGES];

    mem_access_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .is_store_i     (is_store_i),
        .funct3_i       (funct3_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .out_valid_o    (link_valid[0]),
        .out_ready_i    (link_ready[0]),
        .out_addr_o     (link_addr[0]),
        .out_mask_o     (link_mask[0]),
        .out_wdata_o    (link_wdata[0]),
        .out_is_store_o (link_store[0]),
        .out_trap_o     (link_trap[0])
    );

    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        pipe_stage u_stage (
            .clk            (clk),
            .rst            (rst),
            .in_valid_i     (link_valid[k]),
            .in_ready_o     (link_ready[k]),
            .in_addr_i      (link_addr[k]),
            .in_mask_i      (link_mask[k]),
            .in_wdata_i     (link_wdata[k]),
            .in_is_store_i  (link_store[k]),
            .in_trap_i      (link_trap[k]),
            .out_valid_o    (link_valid[k+1]),
            .out_ready_i    (link_ready[k+1]),
            .out_addr_o     (link_addr[k+1]),
            .out_mask_o     (link_mask[k+1]),
            .out_wdata_o    (link_wdata[k+1]),
            .out_is_store_o (link_store[k+1]),
            .out_trap_o     (link_trap[k+1])
        );
    end

    commit_tagger u_tagger (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (link_valid[NUM_STAGES]),
        .in_ready_o  (link_ready[NUM_STAGES]),
        .in_order_o  (out_order_o),
        .out_ready_i (out_ready_i)
    );

    // last link leaves the design directly
    assign out_valid_o    = link_valid[NUM_STAGES];
    assign out_addr_o     = link_addr[NUM_STAGES];
    assign out_mask_o     = link_mask[NUM_STAGES];
    assign out_wdata_o    = link_wdata[NUM_STAGES];
    assign out_is_store_o = link_store[NUM_STAGES];
    assign out_trap_o     = link_trap[NUM_STAGES];

endmodule : lsu_pipe_top

//--- testbench/lsu_tb.sv
module lsu_tb
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200; // cycles per wait loop

    logic    clk;
    logic    rst;
    logic    in_valid_i;
    logic    in_ready_o;
    logic    is_store_i;
    funct3_t funct3_i;
    word_t   addr_i;
    word_t   wdata_i;
    logic    out_valid_o;
    logic    out_ready_i;
    word_t   out_addr_o;
    strb_t   out_mask_o;
    word_t   out_wdata_o;
    logic    out_is_store_o;
    logic    out_trap_o;
    order_t  out_order_o;

    typedef logic [69:0] resp_t; // addr, mask, wdata, is_store, trap

    int     seed;
    int     cycle = 0;
    int     errors;
    int     tests_ok;
    int     tests_bad;
    order_t next_order;
    resp_t  exp_q[$];
    resp_t  obs_q[$];
    int     exp_cyc_q[$];
    int     obs_cyc_q[$];
    order_t obs_order_q[$];

    lsu_pipe_top u_lsu_pipe_top (.*);

    initial begin : clk_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin : out_monitor
        if (!rst && out_valid_o && out_ready_i) begin // transfer on the next edge
            obs_q.push_back({out_addr_o, out_mask_o, out_wdata_o, out_is_store_o, out_trap_o});
            obs_order_q.push_back(out_order_o);
            obs_cyc_q.push_back(cycle + 1); // count of the output transfer edge
        end
    end

    task automatic show_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        $display("FAILED at %0d ns: %s expected %0h got %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
            show_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic compare_mask(input string name, input strb_t exp, input strb_t act);
        if (exp !== act)
            show_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic compare_order(input string name, input order_t exp, input order_t act);
        if (exp !== act)
            show_mismatch(name, exp, act);
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            show_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic push_expected(input logic st, input funct3_t f3, input word_t addr,
                                 input word_t wd);
        int    size;
        int    ofs;
        logic  trap;
        strb_t mask;
        word_t data;
        ofs  = int'(addr[1:0]);
        mask = '0;
        data = '0;
        case ({st, f3})
            {1'b0, lb}, {1'b0, lbu}, {1'b1, sb}: size = 1;
            {1'b0, lh}, {1'b0, lhu}, {1'b1, sh}: size = 2;
            {1'b0, lw}, {1'b1, sw}:              size = 4;
            default:                             size = 0; // no such access
        endcase
        if (size == 0)
            trap = 1'b1;
        else
            trap = (ofs % size) != 0; // natural alignment only
        for (int i = 0; i < STRB_W; i++)
            if (!trap && i >= ofs && i < ofs + size)
                mask = mask | strb_t'(1 << i);
        if (st && !trap)
            data = wd << (8 * ofs);
        exp_q.push_back({(trap ? addr : addr & ~word_t'(3)), mask, data, st, trap});
        exp_cyc_q.push_back(cycle);
    endtask

    task automatic send_req(input logic st, input funct3_t f3, input word_t addr,
                            input word_t wd);
        int   waited;
        logic taken;
        waited     = 0;
        taken      = 1'b0;
        in_valid_i = 1'b1;
        is_store_i = st;
        funct3_i   = f3;
        addr_i     = addr;
        wdata_i    = wd;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            taken = in_ready_o;
            @(posedge clk);
            #1;
            waited++;
        end
        in_valid_i = 1'b0;
        if (taken)
            push_expected(st, f3, addr, wd);
        else begin
            $display("%0d ns: request to %h was never accepted", $time, addr);
            errors++;
        end
    endtask

    task automatic check_outputs(input logic check_latency);
        int    waited;
        int    lat;
        resp_t e;
        resp_t o;
        waited = 0;
        while (obs_q.size() < exp_q.size() && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (obs_q.size() != exp_q.size()) begin
            $display("%0d ns: %0d responses expected but %0d arrived", $time,
                     exp_q.size(), obs_q.size());
            errors++;
        end
        while (exp_q.size() > 0 && obs_q.size() > 0) begin
            e = exp_q.pop_front();
            o = obs_q.pop_front();
            compare_word("out_addr_o", e[69:38], o[69:38]);
            compare_mask("out_mask_o", e[37:34], o[37:34]);
            compare_word("out_wdata_o", e[33:2], o[33:2]);
            compare_bit("out_is_store_o", e[1], o[1]);
            compare_bit("out_trap_o", e[0], o[0]);
            compare_order("out_order_o", next_order, obs_order_q.pop_front());
            next_order = next_order + order_t'(1);
            lat = obs_cyc_q.pop_front() - exp_cyc_q.pop_front();
            if (check_latency && lat != NUM_STAGES + 1)
                show_mismatch("out_valid_o latency", 64'(NUM_STAGES + 1), 64'(lat));
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_ok++;
            $display("%0d ns: test %s done without errors", $time, name);
        end else begin
            tests_bad++;
            $display("%0d ns: test %s done with %0d errors", $time, name, errors - errors_before);
        end
    endtask

    task automatic send_aligned_words();
        int e0;
        e0 = errors;
        compare_bit("out_valid_o", 1'b0, out_valid_o);
        compare_bit("in_ready_o", 1'b1, in_ready_o);
        send_req(1'b0, lw, 32'h0000_1000, 32'hDEAD_BEEF); // load data must come out zero
        send_req(1'b1, sw, 32'h0000_1004, 32'hCAFE_F00D);
        check_outputs(1'b1);
        finish_test("aligned word access", e0);
    endtask

    task automatic sweep_lanes();
        int    e0;
        word_t a;
        e0 = errors;
        for (int ofs = 0; ofs < STRB_W; ofs++) begin
            a = 32'h0000_3000 + word_t'(ofs);
            send_req(1'b1, sb, a, 32'h1122_3344);
            send_req(1'b0, lb, a, '0);
            send_req(1'b0, lbu, a, '0);
            if (ofs % 2 == 0) begin
                send_req(1'b1, sh, a, 32'h5566_7788);
                send_req(1'b0, lh, a, '0);
                send_req(1'b0, lhu, a, '0);
            end
        end
        check_outputs(1'b0);
        finish_test("byte and halfword lanes", e0);
    endtask

    task automatic provoke_traps();
        int e0;
        e0 = errors;
        for (int ofs = 1; ofs < STRB_W; ofs++)
            send_req(1'b0, lw, 32'h0000_4000 + word_t'(ofs), '0);
        send_req(1'b1, sh, 32'h0000_4101, 32'hA5A5_5A5A);
        send_req(1'b1, sh, 32'h0000_4103, 32'hA5A5_5A5A);
        send_req(1'b0, lh, 32'h0000_4203, '0);
        send_req(1'b0, funct3_t'(3), 32'h0000_5000, '0);
        send_req(1'b0, funct3_t'(6), 32'h0000_5000, '0);
        send_req(1'b0, funct3_t'(7), 32'h0000_5000, '0);
        for (int f = 3; f < 8; f++)
            send_req(1'b1, funct3_t'(f), 32'h0000_5100, 32'h1234_5678);
        check_outputs(1'b0);
        finish_test("misaligned and illegal accesses", e0);
    endtask

    task automatic stall_randomly();
        int          e0;
        logic        sending;
        logic [31:0] rnd;
        logic        st_a   [20];
        funct3_t     f3_a   [20];
        word_t       addr_a [20];
        word_t       wd_a   [20];
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            rnd       = $random(seed);
            st_a[i]   = rnd[0];
            f3_a[i]   = rnd[3:1];
            addr_a[i] = $random(seed);
            wd_a[i]   = $random(seed);
        end
        sending = 1'b1;
        fork
            begin
                for (int i = 0; i < 20; i++)
                    send_req(st_a[i], f3_a[i], addr_a[i], wd_a[i]);
                sending = 1'b0;
            end
            while (sending) begin
                rnd         = $random(seed);
                out_ready_i = rnd[0]; // random back-pressure
                @(posedge clk);
                #1;
            end
        join
        out_ready_i = 1'b1;
        check_outputs(1'b0);
        finish_test("random back-pressure", e0);
    endtask

    task automatic fill_and_drain();
        int    e0;
        int    accepted;
        logic  stalled;
        word_t a;
        word_t wd;
        e0          = errors;
        accepted    = 0;
        stalled     = 1'b0;
        out_ready_i = 1'b0;
        while (!stalled && accepted <= NUM_STAGES + 1) begin
            a          = 32'h0000_6000 + word_t'(4 * accepted);
            wd         = 32'h0600_0000 + word_t'(accepted);
            in_valid_i = 1'b1;
            is_store_i = 1'b1;
            funct3_i   = sw;
            addr_i     = a;
            wdata_i    = wd;
            @(negedge clk);
            if (in_ready_o) begin
                @(posedge clk);
                #1;
                push_expected(1'b1, sw, a, wd);
                accepted++;
            end else
                stalled = 1'b1;
        end
        if (accepted != NUM_STAGES + 1)
            show_mismatch("requests accepted before stall", 64'(NUM_STAGES + 1), 64'(accepted));
        if (stalled) begin
            @(posedge clk);
            #1;
        end
        out_ready_i = 1'b1;
        send_req(1'b1, sw, a, wd); // the blocked request enters last
        check_outputs(1'b0);
        finish_test("full pipeline stall", e0);
    endtask

    initial begin : main
        seed        = 2788;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        next_order  = '0;
        rst         = 1'b1;
        in_valid_i  = 1'b0;
        is_store_i  = 1'b0;
        funct3_i    = '0;
        addr_i      = '0;
        wdata_i     = '0;
        out_ready_i = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        send_aligned_words();
        sweep_lanes();
        provoke_traps();
        stall_randomly();
        fill_and_drain();
        $display("%0d tests ok, %0d tests bad, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : lsu_tb

//--- flist.f
rtl/lsu_pkg.sv
rtl/mem_access_decode.sv
rtl/pipe_stage.sv
rtl/commit_tagger.sv
rtl/lsu_pipe_top.sv
testbench/lsu_tb.sv

//--- run.sh
#!/bin/sh
# build lsu_tb with Verilator, run it and scan the log for the verdict

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lsu_tb -Mdir "$OBJ_DIR" -o lsu_sim -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/lsu_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
